//--- hw/mk14_defs.svh
// MK14 display subsystem constants
`ifndef MK14_DEFS_SVH
`define MK14_DEFS_SVH

// cpu bus address width.
`define MK14_ADDR_W 16

// seven-segment digits on the led module.
`define MK14_DIGITS 8

// page bases, only the low 12 address bits are decoded.
`define MK14_RAM_BASE 12'hF00
`define MK14_DISP_BASE 12'hD00
`define MK14_CFG_BASE 12'hE00

// scratch ram size in bytes.
`define MK14_RAM_DEPTH 256

// refresh period loaded at reset, in cycles.
`define MK14_PERIOD_RST 20

`endif

//--- hw/mk14_pkg.sv
// MK14 display subsystem types
`include "mk14_defs.svh"

package mk14_pkg;

	// one cpu request, held stable while ready is low.
	typedef struct packed {
		logic                    valid;
		logic                    write;
		logic [`MK14_ADDR_W-1:0] addr;
		logic [7:0]              wdata;
	} bus_req_t;

	// read data, valid one cycle after the read transfers.
	typedef struct packed {
		logic       valid;
		logic [7:0] rdata;
	} bus_rsp_t;

	// debounced key change.
	typedef struct packed {
		logic       valid;
		logic [2:0] row;
		logic [2:0] col;
		logic       pressed;
	} key_evt_t;

	// register 0xE01 packs enable in bit 3 over brightness in bits 2:0.
	typedef struct packed {
		logic [7:0] period;
		logic [2:0] brightness;
		logic       enable;
	} refresh_cfg_t;

endpackage

//--- hw/mk14_mem_map.sv
// MK14 memory map
`include "mk14_defs.svh"

module mk14_mem_map (
	input  logic                  clk,
	input  logic                  rst_n,
	input  mk14_pkg::bus_req_t    i_bus,
	output logic                  o_bus_ready,
	output mk14_pkg::bus_rsp_t    o_bus_rsp,
	input  mk14_pkg::key_evt_t    i_key,
	input  mk14_pkg::refresh_cfg_t i_cfg,
	output logic                  o_cfg_we,
	output logic                  o_cfg_sel,
	output logic [7:0]            o_cfg_wdata,
	input  logic                  i_dig_rd,
	input  logic [2:0]            i_dig_idx,
	output logic [7:0]            o_dig_data
);

	localparam logic [3:0] RAM_PAGE  = 4'(`MK14_RAM_BASE >> 8);
	localparam logic [3:0] DISP_PAGE = 4'(`MK14_DISP_BASE >> 8);
	localparam logic [3:0] CFG_PAGE  = 4'(`MK14_CFG_BASE >> 8);
	localparam int RAM_AW = $clog2(`MK14_RAM_DEPTH);

	logic [7:0] ram      [`MK14_RAM_DEPTH];
	logic [7:0] dig_ram  [`MK14_DIGITS];
	logic [7:0] kbd_rows [`MK14_DIGITS];

	logic [11:0] a12;
	logic [3:0]  page;
	logic        disp_page;
	logic        ram_hit;
	logic        dig_hit;
	logic        cfg_hit;
	logic        xfer;
	logic        rd_xfer;
	logic        wr_xfer;
	logic [7:0]  rd_data;
	logic [7:0]  ram_q;
	logic [7:0]  rd_q;
	logic        rd_ram_q;
	logic        rsp_valid_q;

	assign a12       = i_bus.addr[11:0];	// upper nibble ignored.
	assign page      = a12[11:8];
	assign disp_page = page == DISP_PAGE;
	assign ram_hit   = page == RAM_PAGE;
	assign dig_hit   = disp_page && (a12[7:0] < 8'(`MK14_DIGITS));
	assign cfg_hit   = (page == CFG_PAGE) && (a12[7:1] == 7'd0);

	// scanner owns the digit ram this cycle.
	assign o_bus_ready = !(i_dig_rd && disp_page);

	assign xfer    = i_bus.valid && o_bus_ready;
	assign rd_xfer = xfer && !i_bus.write;
	assign wr_xfer = xfer && i_bus.write;

	assign o_cfg_we    = wr_xfer && cfg_hit;
	assign o_cfg_sel   = a12[0];
	assign o_cfg_wdata = i_bus.wdata;

	always_ff @(posedge clk) begin
		if (wr_xfer && ram_hit)
			ram[a12[RAM_AW-1:0]] <= i_bus.wdata;
		if (rd_xfer)
			ram_q <= ram[a12[RAM_AW-1:0]];
	end

	// single port, the scanner read wins.
	always_ff @(posedge clk) begin
		if (i_dig_rd)
			o_dig_data <= dig_ram[i_dig_idx];
		else if (wr_xfer && dig_hit)
			dig_ram[a12[2:0]] <= i_bus.wdata;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `MK14_DIGITS; i++)
				kbd_rows[i] <= 8'hFF;
		end else if (i_key.valid) begin
			kbd_rows[i_key.row][i_key.col] <= !i_key.pressed;	// active low keys.
		end
	end

	always_comb begin
		rd_data = 8'hFF;
		if (dig_hit)
			rd_data = kbd_rows[a12[2:0]];	// digit reads see the keyboard.
		else if (cfg_hit)
			rd_data = a12[0] ? {4'd0, i_cfg.enable, i_cfg.brightness} : i_cfg.period;
	end

	always_ff @(posedge clk) begin
		if (rd_xfer) begin
			rd_q     <= rd_data;
			rd_ram_q <= ram_hit;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			rsp_valid_q <= 1'b0;
		else
			rsp_valid_q <= rd_xfer;
	end

	assign o_bus_rsp = '{valid: rsp_valid_q, rdata: rd_ram_q ? ram_q : rd_q};

endmodule

//--- hw/refresh_cfg_regs.sv
// Refresh configuration registers
`include "mk14_defs.svh"

module refresh_cfg_regs (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_we,
	input  logic                   i_sel,
	input  logic [7:0]             i_wdata,
	output mk14_pkg::refresh_cfg_t o_cfg
);

	logic [7:0] period;
	logic [2:0] brightness;
	logic       enable;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			period     <= 8'(`MK14_PERIOD_RST);
			brightness <= 3'd7;
			enable     <= 1'b1;
		end else if (i_we) begin
			if (!i_sel) begin
				// zero would stall the countdown.
				period <= (i_wdata == 8'd0) ? 8'd1 : i_wdata;
			end else begin
				brightness <= i_wdata[2:0];
				enable     <= i_wdata[3];
			end
		end
	end

	assign o_cfg = '{period: period, brightness: brightness, enable: enable};

endmodule

//--- hw/display_refresh_ctrl.sv
// Display refresh period control
`include "mk14_defs.svh"

module display_refresh_ctrl (
	input  logic                   clk,
	input  logic                   rst_n,
	input  mk14_pkg::refresh_cfg_t i_cfg,
	input  logic                   i_scan_idle,
	output logic                   o_scan_start
);

	logic [7:0] cnt;
	logic       at_zero;

	assign at_zero = cnt == 8'd0;

	// reload with period-1 so a zero comes every period cycles.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= 8'(`MK14_PERIOD_RST - 1);
		end else if (i_cfg.enable) begin
			if (at_zero)
				cnt <= i_cfg.period - 8'd1;	// new period picked up here.
			else
				cnt <= cnt - 8'd1;
		end
	end

	// a busy scanner skips this period.
	assign o_scan_start = i_cfg.enable && at_zero && i_scan_idle;

endmodule

//--- hw/tm1638_scanner.sv
// TM1638 frame scanner
`include "mk14_defs.svh"

module tm1638_scanner #(
	parameter int CLK_DIV = 4
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_start,
	input  logic [2:0] i_brightness,
	output logic       o_idle,
	output logic       o_dig_rd,
	output logic [2:0] o_dig_idx,
	input  logic [7:0] i_dig_data,
	output logic       o_tm_clk,
	output logic       o_tm_stb,
	output logic       o_tm_dio
);

	localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam logic [4:0] LAST_DIG_STEP = 5'(2 * `MK14_DIGITS + 1);
	localparam logic [4:0] CTRL_STEP = LAST_DIG_STEP + 5'd1;

	typedef enum logic [2:0] {
		S_IDLE,
		S_START,
		S_PREP,
		S_LOAD,
		S_LOW,
		S_HIGH,
		S_GAP
	} state_t;

	state_t           state;
	logic [4:0]       step;	// byte position in the frame.
	logic [4:0]       step_off;
	logic [2:0]       bit_cnt;
	logic [DIV_W-1:0] div_cnt;
	logic             timed;
	logic             half_done;
	logic             is_dig;
	logic             group_end;
	logic [7:0]       cmd_byte;
	logic [7:0]       next_byte;
	logic [7:0]       sh;

	assign step_off  = step - 5'd2;
	assign is_dig    = (step >= 5'd2) && (step <= LAST_DIG_STEP) && !step_off[0];
	assign group_end = (step == 5'd0) || (step == LAST_DIG_STEP) || (step == CTRL_STEP);

	always_comb begin
		case (step)
			5'd0:      cmd_byte = 8'h40;	// write data, auto increment.
			5'd1:      cmd_byte = 8'hC0;	// address 0.
			CTRL_STEP: cmd_byte = 8'h88 | {5'd0, i_brightness};
			default:   cmd_byte = 8'h00;	// led byte between digits.
		endcase
	end

	assign next_byte = is_dig ? i_dig_data : cmd_byte;

	assign o_dig_rd  = (state == S_PREP) && is_dig;
	assign o_dig_idx = step_off[3:1];
	assign o_idle    = state == S_IDLE;

	assign timed     = (state == S_START) || (state == S_LOW) ||
	                   (state == S_HIGH) || (state == S_GAP);
	assign half_done = div_cnt == DIV_W'(CLK_DIV - 1);

	always_ff @(posedge clk) begin
		if (state == S_LOAD)
			sh <= {1'b0, next_byte[7:1]};
		else if ((state == S_HIGH) && half_done && (bit_cnt != 3'd7))
			sh <= {1'b0, sh[7:1]};
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= S_IDLE;
			step     <= 5'd0;
			bit_cnt  <= 3'd0;
			div_cnt  <= '0;
			o_tm_clk <= 1'b1;
			o_tm_stb <= 1'b1;
			o_tm_dio <= 1'b0;
		end else begin
			if (timed && !half_done)
				div_cnt <= div_cnt + 1'b1;
			else
				div_cnt <= '0;

			case (state)
				S_IDLE: begin
					if (i_start) begin
						step     <= 5'd0;
						o_tm_stb <= 1'b0;
						state    <= S_START;
					end
				end
				S_START: begin
					if (half_done)
						state <= S_PREP;
				end
				S_PREP: state <= S_LOAD;	// digit read in flight.
				S_LOAD: begin
					o_tm_clk <= 1'b0;
					o_tm_dio <= next_byte[0];	// lsb first.
					bit_cnt  <= 3'd0;
					state    <= S_LOW;
				end
				S_LOW: begin
					if (half_done) begin
						o_tm_clk <= 1'b1;
						state    <= S_HIGH;
					end
				end
				S_HIGH: begin
					if (half_done) begin
						if (bit_cnt != 3'd7) begin
							bit_cnt  <= bit_cnt + 3'd1;
							o_tm_clk <= 1'b0;
							o_tm_dio <= sh[0];
							state    <= S_LOW;
						end else if (group_end) begin
							o_tm_stb <= 1'b1;
							state    <= S_GAP;
						end else begin
							step  <= step + 5'd1;
							state <= S_PREP;
						end
					end
				end
				S_GAP: begin
					if (half_done) begin
						if (step == CTRL_STEP) begin
							state <= S_IDLE;
						end else begin
							step     <= step + 5'd1;
							o_tm_stb <= 1'b0;
							state    <= S_START;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

//--- hw/mk14_display_top.sv
// MK14 display and keyboard top
module mk14_display_top #(
	parameter int CLK_DIV = 4
) (
	input  logic               clk,
	input  logic               rst_n,
	input  mk14_pkg::bus_req_t i_bus,
	output logic               o_bus_ready,
	output mk14_pkg::bus_rsp_t o_bus_rsp,
	input  mk14_pkg::key_evt_t i_key,
	output logic               o_tm_clk,
	output logic               o_tm_stb,
	output logic               o_tm_dio
);

	mk14_pkg::refresh_cfg_t cfg;

	logic       cfg_we;
	logic       cfg_sel;
	logic [7:0] cfg_wdata;
	logic       scan_start;
	logic       scan_idle;
	logic       dig_rd;
	logic [2:0] dig_idx;
	logic [7:0] dig_data;

	mk14_mem_map mk14_mem_map_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_bus       (i_bus),
		.o_bus_ready (o_bus_ready),
		.o_bus_rsp   (o_bus_rsp),
		.i_key       (i_key),
		.i_cfg       (cfg),
		.o_cfg_we    (cfg_we),
		.o_cfg_sel   (cfg_sel),
		.o_cfg_wdata (cfg_wdata),
		.i_dig_rd    (dig_rd),
		.i_dig_idx   (dig_idx),
		.o_dig_data  (dig_data)
	);

	refresh_cfg_regs refresh_cfg_regs_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_we    (cfg_we),
		.i_sel   (cfg_sel),
		.i_wdata (cfg_wdata),
		.o_cfg   (cfg)
	);

	display_refresh_ctrl display_refresh_ctrl_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_cfg        (cfg),
		.i_scan_idle  (scan_idle),
		.o_scan_start (scan_start)
	);

	tm1638_scanner #(
		.CLK_DIV (CLK_DIV)
	) tm1638_scanner_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_start      (scan_start),
		.i_brightness (cfg.brightness),
		.o_idle       (scan_idle),
		.o_dig_rd     (dig_rd),
		.o_dig_idx    (dig_idx),
		.i_dig_data   (dig_data),
		.o_tm_clk     (o_tm_clk),
		.o_tm_stb     (o_tm_stb),
		.o_tm_dio     (o_tm_dio)
	);

endmodule

//--- tests/tb_mk14_assert.sv
// Bus and TM1638 protocol checks
module tb_mk14_assert (
	input logic               clk,
	input logic               rst_n,
	input mk14_pkg::bus_req_t i_bus,
	input logic               i_bus_ready,
	input mk14_pkg::bus_rsp_t i_bus_rsp,
	input logic               i_scan_start,
	input logic               i_scan_idle,
	input logic               i_tm_clk,
	input logic               i_tm_stb,
	input logic               i_tm_dio
);

	int   err_cnt = 0;
	logic rd_xfer;

	assign rd_xfer = i_bus.valid && i_bus_ready && !i_bus.write;

	rsp_after_read: assert property (@(posedge clk) disable iff (!rst_n)
		rd_xfer |=> i_bus_rsp.valid)
	else begin
		$error("read transfer without a response one cycle later");
		err_cnt++;
	end

	no_rsp_without_read: assert property (@(posedge clk) disable iff (!rst_n)
		!rd_xfer |=> !i_bus_rsp.valid)
	else begin
		$error("response valid without a read one cycle earlier");
		err_cnt++;
	end

	// an idle scanner takes the start and opens a frame.
	start_only_idle: assert property (@(posedge clk) disable iff (!rst_n)
		i_scan_start |-> (i_scan_idle && i_tm_stb) ##1 (!i_scan_idle && !i_tm_stb))
	else begin
		$error("scan start was not taken by an idle scanner");
		err_cnt++;
	end

	clk_high_with_stb: assert property (@(posedge clk) disable iff (!rst_n)
		i_tm_stb |-> i_tm_clk)
	else begin
		$error("tm clock low while strobe is high");
		err_cnt++;
	end

	// data only moves in the low half.
	dio_stable_high: assert property (@(posedge clk) disable iff (!rst_n)
		i_tm_clk |-> $stable(i_tm_dio))
	else begin
		$error("tm data changed while tm clock was high");
		err_cnt++;
	end

	req_held_stall: assert property (@(posedge clk) disable iff (!rst_n)
		(i_bus.valid && !i_bus_ready) |=> $stable(i_bus))
	else begin
		$error("bus request changed while ready was low");
		err_cnt++;
	end

endmodule

bind mk14_display_top tb_mk14_assert tb_mk14_assert_i (
	.clk          (clk),
	.rst_n        (rst_n),
	.i_bus        (i_bus),
	.i_bus_ready  (o_bus_ready),
	.i_bus_rsp    (o_bus_rsp),
	.i_scan_start (scan_start),
	.i_scan_idle  (scan_idle),
	.i_tm_clk     (o_tm_clk),
	.i_tm_stb     (o_tm_stb),
	.i_tm_dio     (o_tm_dio)
);

//--- tests/tb_mk14.sv
// MK14 display subsystem testbench
`include "mk14_defs.svh"

module tb_mk14;

	localparam int DLY       = 10;
	localparam int READY_TMO = 200;
	localparam int FRAME_TMO = 4000;

	logic               clk;
	logic               rst_n;
	mk14_pkg::bus_req_t i_bus;
	logic               o_bus_ready;
	mk14_pkg::bus_rsp_t o_bus_rsp;
	mk14_pkg::key_evt_t i_key;
	logic               o_tm_clk;
	logic               o_tm_stb;
	logic               o_tm_dio;

	int         seed = 7;
	logic [7:0] ram_sh [`MK14_RAM_DEPTH];
	logic [7:0] dig_sh [`MK14_DIGITS];
	logic [7:0] row_sh [`MK14_DIGITS];
	logic [7:0] period_sh;
	logic [2:0] bri_sh;
	logic       en_sh;
	logic [7:0] exp_q [$];	// reads in flight.
	logic [7:0] rsp_exp;
	int         stall_cnt = 0;

	logic       tm_clk_d = 1'b1;
	logic       tm_stb_d = 1'b1;
	logic [7:0] rx_byte = 8'h00;
	int         rx_bits = 0;
	logic [7:0] cur_grp [$];
	logic [7:0] frame [$];
	logic [7:0] last_frame [$];
	int         frame_start = 0;
	int         cur_id = 0;
	int         last_id = 0;
	int         stb_falls = 0;

	mk14_display_top #(
		.CLK_DIV (2)
	) mk14_display_top_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_bus       (i_bus),
		.o_bus_ready (o_bus_ready),
		.o_bus_rsp   (o_bus_rsp),
		.i_key       (i_key),
		.o_tm_clk    (o_tm_clk),
		.o_tm_stb    (o_tm_stb),
		.o_tm_dio    (o_tm_dio)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic report_problem(input string msg);
		$display("%s", msg);
		abort_run();
	endtask

	task automatic check_eq(input string name, input logic [7:0] exp, input logic [7:0] got);
		assert (got === exp)
		else begin
			$display("[FAIL] %s expected 0x%02h got 0x%02h", name, exp, got);
			abort_run();
		end
	endtask

	// entered and left at a rising edge plus DLY.
	task automatic bus_xfer(input logic wr, input logic [15:0] addr, input logic [7:0] wdata,
			input logic [7:0] exp_rd);
		int t;
		t = 0;
		i_bus = '{valid: 1'b1, write: wr, addr: addr, wdata: wdata};
		@(negedge clk);
		while (!o_bus_ready) begin
			if (t >= READY_TMO)
				report_problem("bus ready stayed low for too long");
			stall_cnt++;
			t++;
			@(negedge clk);
		end
		if (!wr)
			exp_q.push_back(exp_rd);
		@(posedge clk);
		#DLY;
		i_bus.valid = 1'b0;
	endtask

	task automatic write_byte(input logic [15:0] addr, input logic [7:0] data);
		bus_xfer(1'b1, addr, data, 8'h00);
	endtask

	task automatic read_expect(input logic [15:0] addr, input logic [7:0] exp);
		bus_xfer(1'b0, addr, 8'h00, exp);
	endtask

	task automatic key_event(input logic [2:0] row, input logic [2:0] col, input logic pressed);
		i_key = '{valid: 1'b1, row: row, col: col, pressed: pressed};
		row_sh[row][col] = !pressed;	// pressed keys read low.
		@(posedge clk);
		#DLY;
		i_key.valid = 1'b0;
	endtask

	task automatic drain_reads();
		int t;
		t = 0;
		while (exp_q.size() != 0) begin
			if (t >= READY_TMO)
				report_problem("a read response never arrived");
			t++;
			@(posedge clk);
			#DLY;
		end
	endtask

	// waits for a frame whose command group ends after this call.
	task automatic check_frame();
		int t;
		int s0;
		t = 0;
		s0 = frame_start;
		@(posedge clk);
		while (last_id <= s0) begin
			if (t >= FRAME_TMO)
				report_problem("no complete display frame arrived in time");
			t++;
			@(posedge clk);
		end
		#DLY;
		if (last_frame.size() != 2 * `MK14_DIGITS + 3)
			report_problem("captured display frame has the wrong number of bytes");
		check_eq("o_tm_dio cmd byte", 8'h40, last_frame[0]);
		check_eq("o_tm_dio addr byte", 8'hC0, last_frame[1]);
		for (int i = 0; i < `MK14_DIGITS; i++) begin
			check_eq($sformatf("o_tm_dio digit %0d", i), dig_sh[i], last_frame[2 + 2 * i]);
			check_eq($sformatf("o_tm_dio led %0d", i), 8'h00, last_frame[3 + 2 * i]);
		end
		check_eq("o_tm_dio ctrl byte", 8'h88 | {5'd0, bri_sh}, last_frame[2 * `MK14_DIGITS + 2]);
	endtask

	task automatic wait_scanner_quiet();
		int t;
		int hi_run;
		t = 0;
		hi_run = 0;
		while (hi_run < 50) begin
			if (t >= FRAME_TMO)
				report_problem("the scanner kept strobing after refresh was disabled");
			t++;
			@(posedge clk);
			#DLY;
			hi_run = o_tm_stb ? hi_run + 1 : 0;
		end
	endtask

	task automatic close_group();
		if (rx_bits != 0)
			report_problem("a strobe group ended in the middle of a byte");
		if (cur_grp.size() != 0 && cur_grp[0] == 8'h40) begin
			frame.delete();
			frame_start++;
			cur_id = frame_start;
		end
		foreach (cur_grp[i])
			frame.push_back(cur_grp[i]);
		if (cur_grp.size() == 1 && cur_grp[0][7:3] == 5'b10001) begin
			last_frame = frame;
			last_id    = cur_id;
		end
		cur_grp.delete();
	endtask

	// serial capture, receiver samples on rising tm clock.
	always @(negedge clk) begin
		if (rst_n) begin
			if (o_tm_clk && !tm_clk_d && !o_tm_stb) begin
				rx_byte = {o_tm_dio, rx_byte[7:1]};	// lsb first.
				rx_bits++;
				if (rx_bits == 8) begin
					cur_grp.push_back(rx_byte);
					rx_bits = 0;
				end
			end
			if (!o_tm_stb && tm_stb_d)
				stb_falls++;
			if (o_tm_stb && !tm_stb_d)
				close_group();
		end
		tm_clk_d = o_tm_clk;
		tm_stb_d = o_tm_stb;
	end

	always @(negedge clk) begin
		if (rst_n && o_bus_rsp.valid) begin
			if (exp_q.size() == 0) begin
				report_problem("a read response arrived with no read pending");
			end else begin
				rsp_exp = exp_q.pop_front();
				check_eq("o_bus_rsp.rdata", rsp_exp, o_bus_rsp.rdata);
			end
		end
	end

	always @(negedge clk)
		if (mk14_display_top_i.tb_mk14_assert_i.err_cnt != 0)
			report_problem("a bound protocol assertion failed");

	initial begin
		repeat (60000) @(posedge clk);
		report_problem("the test ran past its cycle limit");
	end

	initial begin
		int         r;
		int         t;
		int         falls0;
		logic [3:0] hi;
		logic [7:0] off;
		logic [7:0] d;
		rst_n     = 1'b0;
		i_bus     = '0;
		i_key     = '0;
		period_sh = 8'(`MK14_PERIOD_RST);
		bri_sh    = 3'd7;
		en_sh     = 1'b1;
		for (int i = 0; i < `MK14_DIGITS; i++)
			row_sh[i] = 8'hFF;
		repeat (7) @(posedge clk);
		@(negedge clk);
		check_eq("o_bus_ready", 8'h01, {7'd0, o_bus_ready});
		check_eq("o_bus_rsp.valid", 8'h00, {7'd0, o_bus_rsp.valid});
		check_eq("o_tm_stb", 8'h01, {7'd0, o_tm_stb});
		check_eq("o_tm_clk", 8'h01, {7'd0, o_tm_clk});
		@(posedge clk);
		#DLY;
		rst_n = 1'b1;

		// scratch ram, any upper nibble aliases.
		for (int i = 0; i < `MK14_RAM_DEPTH; i++) begin
			d  = $random(seed);
			hi = $random(seed);
			write_byte({hi, 4'hF, 8'(i)}, d);
			ram_sh[i] = d;
		end
		repeat (64) begin
			off = $random(seed);
			hi  = $random(seed);
			read_expect({hi, 4'hF, off}, ram_sh[off]);
		end
		read_expect(16'h0123, 8'hFF);
		read_expect(16'h1D08, 8'hFF);
		drain_reads();

		repeat (24) begin
			r = $random(seed);
			key_event(r[2:0], r[5:3], r[6]);
		end
		for (int i = 0; i < `MK14_DIGITS; i++)
			read_expect({4'h0, `MK14_DISP_BASE} + 16'(i), row_sh[i]);
		drain_reads();

		for (int i = 0; i < `MK14_DIGITS; i++) begin
			d = $random(seed);
			write_byte({4'h0, `MK14_DISP_BASE} + 16'(i), d);
			dig_sh[i] = d;
		end
		check_frame();

		write_byte({4'h0, `MK14_CFG_BASE} + 16'd1, {4'd0, 1'b1, 3'd3});
		bri_sh = 3'd3;
		write_byte({4'h0, `MK14_CFG_BASE}, 8'h18);
		period_sh = 8'h18;
		read_expect({4'h0, `MK14_CFG_BASE}, period_sh);
		read_expect({4'h0, `MK14_CFG_BASE} + 16'd1, {4'd0, en_sh, bri_sh});
		drain_reads();
		check_frame();

		// digit page traffic that collides with scanner fetches.
		stall_cnt = 0;
		t = 0;
		while (stall_cnt < 6) begin
			if (t >= 4000)
				report_problem("digit page traffic never met a scanner fetch");
			t++;
			r = $random(seed);
			if (r[3]) begin
				write_byte({4'h0, `MK14_DISP_BASE} + 16'(r[2:0]), r[15:8]);
				dig_sh[r[2:0]] = r[15:8];
			end else begin
				read_expect({4'h0, `MK14_DISP_BASE} + 16'(r[2:0]), row_sh[r[2:0]]);
			end
		end
		drain_reads();
		check_frame();

		write_byte({4'h0, `MK14_CFG_BASE} + 16'd1, {4'd0, 1'b0, bri_sh});
		en_sh = 1'b0;
		read_expect({4'h0, `MK14_CFG_BASE} + 16'd1, {4'd0, en_sh, bri_sh});
		drain_reads();
		wait_scanner_quiet();
		falls0 = stb_falls;
		repeat (2000) @(posedge clk);
		#DLY;
		if (stb_falls != falls0)
			report_problem("a display frame started while refresh was disabled");

		if (mk14_display_top_i.tb_mk14_assert_i.err_cnt == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("Result: FAILED");
			$fatal(1);
		end
	end

endmodule

//--- tb.f
+incdir+hw
hw/mk14_pkg.sv
hw/mk14_mem_map.sv
hw/refresh_cfg_regs.sv
hw/display_refresh_ctrl.sv
hw/tm1638_scanner.sv
hw/mk14_display_top.sv
tests/tb_mk14_assert.sv
tests/tb_mk14.sv

//--- Bender.yml
package:
  name: mk14_display

sources:
  - include_dirs:
      - hw
    files:
      - hw/mk14_pkg.sv
      - hw/mk14_mem_map.sv
      - hw/refresh_cfg_regs.sv
      - hw/display_refresh_ctrl.sv
      - hw/tm1638_scanner.sv
      - hw/mk14_display_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_mk14_assert.sv
      - tests/tb_mk14.sv
